//--- logic/gf_pkg.sv
package gf_pkg;

	// GF(2^4) with x^4 + x + 1, the usual field for short BCH codes
	localparam int GF_M = 4;
	localparam logic [GF_M-1:0] GF_POLY = 4'b0011; // x^4 folds back onto x + 1

	typedef logic [GF_M-1:0] gf_elem_t; // one element, standard basis unless named dual

	// division request as the sender hands it in
	typedef struct packed {
		gf_elem_t numer;
		gf_elem_t denom;
	} gf_req_t;

	// division result as the receiver sees it
	typedef struct packed {
		gf_elem_t quot;    // numer / denom, standard basis
		logic div_by_zero; // denom was zero, quot is forced to zero
	} gf_res_t;

	// multiply by alpha in standard basis: shift up and reduce the carry
	function automatic gf_elem_t gf_mul_alpha(input gf_elem_t x);
		return {x[GF_M-2:0], 1'b0} ^ (x[GF_M-1] ? GF_POLY : '0);
	endfunction

	// alpha^k in standard basis, meant for elaboration time only
	function automatic gf_elem_t gf_alpha_pow(input int k);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < k; i++)
			r = gf_mul_alpha(r); // k stays small, no need to reduce it mod 2^m-1
		return r;
	endfunction

	// dual coordinates d[i] = f(alpha^i * x) with f picking the constant coefficient
	// any nonzero linear f gives a valid dual basis and this one costs nothing
	function automatic gf_elem_t gf_std_to_dual(input gf_elem_t x);
		gf_elem_t d;
		gf_elem_t r;
		r = x;
		for (int i = 0; i < GF_M; i++) begin
			d[i] = r[0];
			r = gf_mul_alpha(r);
		end
		return d;
	endfunction

	// standard-basis element whose dual form is the unit vector i
	// found by search since the field is tiny and this only runs at elaboration
	function automatic gf_elem_t gf_dual_unit(input int i);
		gf_elem_t r;
		r = '0;
		for (int x = 0; x < (1 << GF_M); x++) begin
			if (gf_std_to_dual(gf_elem_t'(x)) == gf_elem_t'(1 << i))
				r = gf_elem_t'(x);
		end
		return r;
	endfunction

endpackage

//--- logic/gf_square.sv
// squaring is linear over GF(2), so a^2 = sum a[j] * alpha^(2j)
// and each result bit is a parity over a fixed mask of a
module gf_square (
	input gf_pkg::gf_elem_t a,
	output gf_pkg::gf_elem_t sq
);
	import gf_pkg::*;

	// column i collects bit i of alpha^(2j) for every j
	function automatic gf_elem_t sq_column(input int i);
		gf_elem_t col;
		gf_elem_t pw;
		col = '0;
		for (int j = 0; j < GF_M; j++) begin
			pw = gf_alpha_pow(2 * j); // where a[j] lands after squaring
			col[j] = pw[i];
		end
		return col;
	endfunction

	for (genvar i = 0; i < GF_M; i++) begin : g_bit
		localparam gf_elem_t COL = sq_column(i);
		assign sq[i] = ^(a & COL); // one xor tree per output bit
	end

endmodule

//--- logic/gf_dual_mult.sv
// bit-parallel Berlekamp multiplier, dual operand times standard operand gives dual
// product bit i is sum_j std_b[j] * d[i+j], where d is the dual operand extended
// past GF_M bits by the same recurrence the field polynomial imposes on alpha
module gf_dual_mult (
	input gf_pkg::gf_elem_t dual_a,
	input gf_pkg::gf_elem_t std_b,
	output gf_pkg::gf_elem_t dual_p
);
	import gf_pkg::*;

	logic [GF_M-2:0] aux; // d[GF_M] .. d[2*GF_M-2]
	logic [2*GF_M-2:0] ext; // the full sliding-window source

	assign ext = {aux, dual_a};

	// each extra term is what one more LFSR step would shift in
	for (genvar i = 0; i < GF_M - 1; i++) begin : g_aux
		assign aux[i] = ^(ext[i+:GF_M] & GF_POLY);
	end

	// window i of the extended vector against the standard operand
	for (genvar i = 0; i < GF_M; i++) begin : g_prod
		assign dual_p[i] = ^(ext[i+:GF_M] & std_b);
	end

endmodule

//--- logic/gf_dual_to_standard.sv
// maps a dual-basis element back to standard basis
// the map is linear, so std_out = sum_i dual_in[i] * e_i with e_i the element
// whose dual form is the unit vector i
module gf_dual_to_standard (
	input gf_pkg::gf_elem_t dual_in,
	output gf_pkg::gf_elem_t std_out
);
	import gf_pkg::*;

	// row j of the inverse matrix holds bit j of every e_i
	function automatic gf_elem_t inv_row(input int j);
		gf_elem_t row;
		gf_elem_t e;
		row = '0;
		for (int i = 0; i < GF_M; i++) begin
			e = gf_dual_unit(i);
			row[i] = e[j];
		end
		return row;
	endfunction

	for (genvar j = 0; j < GF_M; j++) begin : g_row
		localparam gf_elem_t ROW = inv_row(j);
		assign std_out[j] = ^(dual_in & ROW); // constant parity, no logic beyond xors
	end

endmodule

//--- logic/gf_req_queue.sv
// request FIFO in front of the divider
// the sender only writes while it holds a credit, so a full queue is never written
module gf_req_queue #(
	parameter int REQ_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic push,
	input gf_pkg::gf_req_t din,
	input logic pop,
	output gf_pkg::gf_req_t head,
	output logic empty
);
	import gf_pkg::*;

	localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(REQ_DEPTH + 1); // has to reach REQ_DEPTH itself

	gf_req_t mem [REQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// pointer step with explicit wrap so depths that are not a power of two work
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(REQ_DEPTH - 1))
			return '0;
		else
			return p + 1'b1;
	endfunction

	assign head = mem[rd_ptr]; // the oldest entry is always on view
	assign empty = (count == '0);

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= din; // storage only, pointers say what is live
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr); // the entry leaves the queue in the pop cycle
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither leave the fill level alone
			endcase
		end
	end

endmodule

//--- logic/gf_div_ctrl.sv
// divider control: result credits, step counter and the Fermat inverse sequence
// numer / denom = numer * denom^(2^m - 2) = numer * prod over k of denom^(2^k), k = 1..m-1
module gf_div_ctrl #(
	parameter int REQ_DEPTH = 4,
	parameter int RES_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input gf_pkg::gf_req_t head,
	input logic empty,
	output logic pop,
	input gf_pkg::gf_elem_t sq,
	output gf_pkg::gf_elem_t sq_src,
	input gf_pkg::gf_elem_t prod,
	output gf_pkg::gf_elem_t acc,
	output gf_pkg::gf_elem_t mul_b,
	input logic res_credit,
	output logic res_valid,
	output logic busy,
	output logic div_by_zero
);
	import gf_pkg::*;

	// counter width covers the larger of the two credit pools
	localparam int CRED_MAX = (RES_CREDITS > REQ_DEPTH) ? RES_CREDITS : REQ_DEPTH;
	localparam int CRED_W = $clog2(CRED_MAX + 1);
	localparam int STEP_W = $clog2(GF_M); // steps run 0 .. GF_M-1
	localparam gf_elem_t DUAL_ONE = gf_std_to_dual(gf_elem_t'(1));

	logic [CRED_W-1:0] res_cred; // results the receiver can still take
	logic [STEP_W-1:0] step;
	gf_elem_t numer_q; // numerator waits here for the last multiply
	gf_elem_t pw; // current power denom^(2^k), standard basis
	logic step_en;
	logic last_step;
	logic pw_load;

	assign step_en = busy && !res_valid; // the result cycle itself does no arithmetic
	assign last_step = step_en && (step == STEP_W'(GF_M - 1));

	// a credit is taken at dequeue so the result can never be refused later
	assign pop = !empty && !busy && (res_cred != '0);

	assign sq_src = pop ? head.denom : pw; // first square comes straight from the queue head
	assign mul_b = last_step ? numer_q : pw; // last multiply folds in the numerator
	assign pw_load = pop || (step_en && !last_step);

	always_ff @(posedge clk) begin
		if (rst) begin
			res_cred <= CRED_W'(RES_CREDITS);
		end else begin
			case ({pop, res_credit})
				2'b10: res_cred <= res_cred - 1'b1; // reserved for the division just started
				2'b01: res_cred <= res_cred + 1'b1;
				default: res_cred <= res_cred;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			res_valid <= 1'b0;
			step <= '0;
		end else begin
			res_valid <= last_step; // one pulse, the edge after the final multiply starts
			if (pop)
				busy <= 1'b1;
			else if (res_valid)
				busy <= 1'b0; // next pop no earlier than the cycle after res_valid
			if (pop)
				step <= '0;
			else if (step_en && !last_step)
				step <= step + 1'b1;
		end
	end

	// datapath registers, only meaningful between pop and res_valid
	always_ff @(posedge clk) begin
		if (pop) begin
			numer_q <= head.numer;
			div_by_zero <= (head.denom == '0); // the only zero test in the design
			acc <= DUAL_ONE;
		end else if (last_step) begin
			acc <= div_by_zero ? '0 : prod;
		end else if (step_en) begin
			acc <= prod; // acc times the next square of denom
		end
		if (pw_load)
			pw <= sq; // squarer runs one step ahead of the multiplier
	end

endmodule

//--- logic/gf_div_top.sv
// GF(2^m) division service
// credit-controlled request queue, one Fermat divider, credit-controlled results
module gf_div_top #(
	parameter int REQ_DEPTH = 4,
	parameter int RES_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input gf_pkg::gf_req_t req,
	output logic req_credit,
	input logic res_credit,
	output logic res_valid,
	output gf_pkg::gf_res_t res
);
	import gf_pkg::*;

	gf_req_t head;
	logic empty;
	logic pop;
	logic div_by_zero;
	gf_elem_t sq_src;
	gf_elem_t sq;
	gf_elem_t acc; // dual basis
	gf_elem_t mul_b;
	gf_elem_t prod; // dual basis
	gf_elem_t quot;

	gf_req_queue #(
		.REQ_DEPTH(REQ_DEPTH)
	) u_queue (
		.clk(clk),
		.rst(rst),
		.push(req_valid), // every valid is backed by a credit
		.din(req),
		.pop(pop),
		.head(head),
		.empty(empty)
	);

	gf_div_ctrl #(
		.REQ_DEPTH(REQ_DEPTH),
		.RES_CREDITS(RES_CREDITS)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.head(head),
		.empty(empty),
		.pop(pop),
		.sq(sq),
		.sq_src(sq_src),
		.prod(prod),
		.acc(acc),
		.mul_b(mul_b),
		.res_credit(res_credit),
		.res_valid(res_valid),
		.busy(),
		.div_by_zero(div_by_zero)
	);

	gf_square u_square (
		.a(sq_src),
		.sq(sq)
	);

	gf_dual_mult u_mult (
		.dual_a(acc),
		.std_b(mul_b),
		.dual_p(prod)
	);

	gf_dual_to_standard u_to_std (
		.dual_in(acc), // acc holds the finished quotient while res_valid is high
		.std_out(quot)
	);

	assign req_credit = pop; // a slot frees up the moment its request is dequeued
	assign res = '{quot: quot, div_by_zero: div_by_zero};

endmodule

//--- dv/gf_div_assertions.sv
// protocol checks on the divider control, attached to every gf_div_ctrl
module gf_div_assertions #(
	parameter int CRED_W = 3,
	parameter int RES_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic pop,
	input logic empty,
	input logic res_valid,
	input logic [CRED_W-1:0] res_cred
);
	timeunit 1ns;
	timeprecision 1ps;
	import gf_pkg::*;

	// a pop reads the queue head, so there has to be one
	pop_needs_entry: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else $error("pop while the request queue is empty");

	// an underflow would wrap the counter far above its reset value
	cred_in_range: assert property (@(posedge clk) disable iff (rst)
		res_cred <= CRED_W'(RES_CREDITS))
		else $error("result credit counter out of range");

	// fixed divider latency, both ways round
	pop_to_valid: assert property (@(posedge clk) disable iff (rst)
		pop |-> ##(GF_M + 1) res_valid)
		else $error("res_valid missing after a pop");

	valid_from_pop: assert property (@(posedge clk) disable iff (rst)
		res_valid |-> $past(pop, GF_M + 1))
		else $error("res_valid without the matching pop");

endmodule

bind gf_div_ctrl gf_div_assertions #(
	.CRED_W(CRED_W),
	.RES_CREDITS(RES_CREDITS)
) u_assertions (
	.clk(clk),
	.rst(rst),
	.pop(pop),
	.empty(empty),
	.res_valid(res_valid),
	.res_cred(res_cred)
);

//--- dv/gf_div_tb.sv
module gf_div_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import gf_pkg::*;

	localparam int REQ_DEPTH = 4; // same as the DUT defaults
	localparam int RES_CREDITS = 2;
	localparam int TABLE_LEN = 16;
	localparam int RAND_LEN = 40;
	localparam int ZERO_LEN = 4;
	localparam int HOLD_LEN = 6;
	localparam int BURST_LEN = 3 * REQ_DEPTH; // three bursts at full credit
	localparam int NUM_REQ = TABLE_LEN + RAND_LEN + ZERO_LEN + HOLD_LEN + BURST_LEN;
	localparam int TIMEOUT = 64 * NUM_REQ; // cycles, generous against about six per request
	localparam logic [31:0] SEED = 32'h6c72_46f2;

	// one request together with the result it has to produce
	typedef struct packed {
		gf_req_t req;
		gf_res_t exp;
	} job_t;

	// inverses in GF(16) mod x^4 + x + 1, index is the element, entry 0 unused
	localparam gf_elem_t INV_TAB [16] = '{4'h0, 4'h1, 4'h9, 4'he, 4'hd, 4'hb, 4'h7, 4'h6,
		4'hf, 4'h2, 4'hc, 4'h5, 4'ha, 4'h4, 4'h3, 4'h8};

	// numer, denom, quot, div_by_zero worked out by hand from alpha logs
	localparam job_t DIV_TABLE [TABLE_LEN] = '{
		{4'h7, 4'h1, 4'h7, 1'b0}, // division by one
		{4'hb, 4'h1, 4'hb, 1'b0},
		{4'h5, 4'h5, 4'h1, 1'b0}, // a value over itself
		{4'he, 4'he, 4'h1, 1'b0},
		{4'h1, 4'h2, 4'h9, 1'b0}, // plain inverses
		{4'h1, 4'h3, 4'he, 1'b0},
		{4'h2, 4'h3, 4'hf, 1'b0},
		{4'h6, 4'h7, 4'h7, 1'b0},
		{4'h0, 4'h9, 4'h0, 1'b0}, // zero numerator stays zero
		{4'hf, 4'h8, 4'ha, 1'b0},
		{4'hd, 4'hb, 4'hc, 1'b0},
		{4'h9, 4'hc, 4'h5, 1'b0},
		{4'ha, 4'hd, 4'he, 1'b0},
		{4'h4, 4'hf, 4'h6, 1'b0},
		{4'h3, 4'h6, 4'h9, 1'b0},
		{4'h8, 4'h0, 4'h0, 1'b1}  // zero denominator at the very end of the table
	};

	logic clk;
	logic rst;
	logic req_valid;
	gf_req_t req;
	logic req_credit;
	logic res_credit;
	logic res_valid;
	gf_res_t res;

	job_t pend_q[$];   // waiting for a request credit
	job_t drive_q[$];  // driven, not yet seen on the DUT input
	job_t flight_q[$]; // accepted, result still to come
	int credits;       // request credits the sender holds
	int owed;          // results consumed whose credit is not returned yet
	int delay;         // receiver pause before the next credit return
	logic withhold;
	int cycles = 0;
	int sent = 0;
	int credit_pulses = 0;
	int received = 0;
	int returned = 0;
	int checks_done = 0;

	gf_div_top uut (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req(req),
		.req_credit(req_credit),
		.res_credit(res_credit),
		.res_valid(res_valid),
		.res(res)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// schoolbook product, then fold bits 7..4 back with x^4 + x + 1
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		logic [7:0] p;
		p = '0;
		for (int i = 0; i < 4; i++) begin
			if (b[i])
				p ^= 8'(a) << i;
		end
		for (int i = 7; i >= 4; i--) begin
			if (p[i])
				p ^= 8'h13 << (i - 4);
		end
		return p[3:0];
	endfunction

	function automatic gf_res_t expected_res(input gf_req_t r);
		if (r.denom == '0)
			return '{quot: '0, div_by_zero: 1'b1};
		return '{quot: gf_mul(r.numer, INV_TAB[r.denom]), div_by_zero: 1'b0};
	endfunction

	task automatic check_res(input string what, input gf_res_t got, input gf_res_t exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s: got quot %h dbz %b, expected quot %h dbz %b",
				$time, what, got.quot, got.div_by_zero, exp.quot, exp.div_by_zero);
			$display("STATUS: FAIL");
			$fatal(1, "stopping at the first error");
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("FAIL at %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "stopping at the first error");
		end
	endtask

	task automatic queue_job(input gf_elem_t numer, input gf_elem_t denom);
		job_t j;
		j.req = '{numer: numer, denom: denom};
		j.exp = expected_res(j.req);
		pend_q.push_back(j);
	endtask

	// everything sent, answered and credited back, plus one edge for the last credit
	task automatic wait_idle();
		while (pend_q.size() != 0 || drive_q.size() != 0 || flight_q.size() != 0 ||
				owed != 0 || res_credit)
			@(negedge clk);
		@(negedge clk);
	endtask

	// sender: spends one credit per request, gets one back per req_credit pulse
	always @(posedge clk) begin : sender
		job_t j;
		if (rst) begin
			req_valid <= 1'b0;
			credits = REQ_DEPTH;
		end else begin
			if (req_credit)
				credits++;
			if (pend_q.size() != 0 && credits > 0) begin
				j = pend_q.pop_front();
				req_valid <= 1'b1;
				req <= j.req;
				credits--;
				drive_q.push_back(j);
			end else begin
				req_valid <= 1'b0;
			end
		end
	end

	// receiver: consumes each result and returns its credit after a short random pause
	always @(posedge clk) begin : receiver
		if (rst) begin
			res_credit <= 1'b0;
			owed = 0;
			delay = 0;
		end else begin
			if (res_valid)
				owed++;
			if (!withhold && owed > 0 && delay == 0) begin
				res_credit <= 1'b1;
				owed--;
				delay = $urandom % 4;
			end else begin
				res_credit <= 1'b0;
				if (delay > 0)
					delay--;
			end
		end
	end

	// monitor samples what the DUT saw at this edge, so it never races the drivers
	always @(posedge clk) begin : monitor
		job_t j;
		gf_res_t back;
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("STATUS: FAIL");
			$fatal(1, "run hung");
		end
		if (!rst) begin
			if (req_credit)
				credit_pulses++;
			if (res_credit)
				returned++;
			if (req_valid) begin
				j = drive_q.pop_front();
				flight_q.push_back(j); // the queue took it at this edge
				sent++;
			end
			if (res_valid) begin
				if (flight_q.size() == 0) begin
					$display("a result came out with no request outstanding at %0t ns", $time);
					$display("STATUS: FAIL");
					$fatal(1, "spurious result");
				end else begin
					j = flight_q.pop_front(); // results keep request order
					if (j.req.denom != '0) begin
						back = '{quot: gf_mul(res.quot, j.req.denom), div_by_zero: 1'b0};
						check_res("quot times denom", back, '{quot: j.req.numer, div_by_zero: 1'b0});
					end
					check_res("quotient", res, j.exp); // also catches a wrong div_by_zero
					received++;
					checks_done++;
					if (received - returned > RES_CREDITS) begin
						$display("more results delivered than result credits allow at %0t ns",
							$time);
						$display("STATUS: FAIL");
						$fatal(1, "credit overrun");
					end
				end
			end
		end
	end

	initial begin : main
		int base;
		gf_elem_t numer;
		gf_elem_t denom;
		void'($urandom(SEED));
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		res_credit = 1'b0;
		withhold = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// quiet after reset
		repeat (20) @(negedge clk);
		check_count("res_valid pulses with no requests", received, 0);
		check_count("req_credit pulses with no requests", credit_pulses, 0);
		for (int x = 1; x < 16; x++)
			check_count("model inverse", int'(gf_mul(gf_elem_t'(x), INV_TAB[x])), 1);

		foreach (DIV_TABLE[i])
			pend_q.push_back(DIV_TABLE[i]);
		wait_idle();

		for (int i = 0; i < RAND_LEN; i++) begin
			numer = gf_elem_t'($urandom);
			denom = gf_elem_t'(1 + $urandom % 15); // nonzero, so the product check applies
			queue_job(numer, denom);
		end
		wait_idle();

		// zero denominators with ordinary requests on both sides
		queue_job(4'h5, 4'h3);
		queue_job(4'h9, 4'h0);
		queue_job(4'h0, 4'h0);
		queue_job(4'hc, 4'h7);
		wait_idle();

		// receiver holds its credits back, only RES_CREDITS results may come out
		withhold = 1'b1;
		base = received;
		for (int i = 0; i < HOLD_LEN; i++) begin
			numer = gf_elem_t'($urandom);
			denom = gf_elem_t'($urandom);
			queue_job(numer, denom);
		end
		while (received < base + RES_CREDITS)
			@(negedge clk);
		repeat (8 * (GF_M + 2)) @(negedge clk); // room for several more divisions
		check_count("results while credits withheld", received - base, RES_CREDITS);
		withhold = 1'b0;
		wait_idle();
		check_count("withheld results delivered", received - base, HOLD_LEN);

		for (int b = 0; b < BURST_LEN / REQ_DEPTH; b++) begin
			check_count("sender credits before burst", credits, REQ_DEPTH);
			base = credit_pulses;
			for (int i = 0; i < REQ_DEPTH; i++) begin
				numer = gf_elem_t'($urandom);
				denom = gf_elem_t'($urandom);
				queue_job(numer, denom);
			end
			wait_idle();
			check_count("req_credit pulses in burst", credit_pulses - base, REQ_DEPTH);
		end

		check_count("req_credit pulses against accepted requests", credit_pulses, sent);

		if (checks_done == NUM_REQ && sent == NUM_REQ && flight_q.size() == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("only %0d of %0d results were checked", checks_done, NUM_REQ);
			$display("STATUS: FAIL");
			$fatal(1, "incomplete run");
		end
	end

endmodule

//--- filelist.f
logic/gf_pkg.sv
logic/gf_square.sv
logic/gf_dual_mult.sv
logic/gf_dual_to_standard.sv
logic/gf_req_queue.sv
logic/gf_div_ctrl.sv
logic/gf_div_top.sv
dv/gf_div_assertions.sv
dv/gf_div_tb.sv
